//--- files.f
+incdir+verilog
verilog/decode_pkg.sv
verilog/opcode_classifier.sv
verilog/displacement_sizer.sv
verilog/operand_selector.sv
verilog/decode_stage.sv
verification/decode_stage_sva.sv
verification/tb_decode_stage.sv

//--- verification/tb_decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module tb_decode_stage;

    logic                     clk;
    logic                     rst_n;
    logic                     in_valid;
    decode_pkg::opcode_t      opcode;
    decode_pkg::modrm_t       modrm;
    logic                     out_valid;
    decode_pkg::decode_info_t info;

    logic [31:0]              lcg_state = 32'd38174;
    int                       cycle = 0;
    int                       check_count = 0;
    int                       error_count = 0;
    int                       error_mark = 0;
    int                       sent_count = 0;
    decode_pkg::decode_info_t exp_q[$];               // Expected info per strobe
    int                       due_q[$];               // Cycle its out_valid is due
    string                    name_q[$];

    decode_stage decode_stage_inst
    (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .opcode    (opcode),
        .modrm     (modrm),
        .out_valid (out_valid),
        .info      (info)
    );

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #5 clk = ~clk;
        end
    end

    always @(posedge clk)
        cycle <= cycle + 1;

    function automatic logic [7:0] random_byte();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[23:16];
    endfunction

    // Expected decode built from the 8086 operand rules
    function automatic decode_pkg::decode_info_t expected_info(input logic [7:0] op,
                                                               input logic [7:0] mb);
        decode_pkg::decode_info_t r;
        logic                     pair;
        logic                     sreg;
        logic                     rm_dst;
        logic                     shift;
        logic                     branch;
        logic                     single;
        logic                     direct;
        logic [3:0]               rg;
        logic [3:0]               rm;
        r      = '0;
        pair   = (op < 8'h40 && !op[2]) || op inside {[8'h88:8'h8B]};
        sreg   = op == 8'h8C || op == 8'h8E;
        rm_dst = op inside {[8'h80:8'h83], 8'hC6, 8'hC7};
        shift  = op inside {8'hC0, 8'hC1, [8'hD0:8'hD3]};
        branch = op inside {[8'h70:8'h7F], 8'hE2, 8'hE9, 8'hEB, 8'h9A, 8'hEA};
        single = op inside {[8'h40:8'h5F], [8'h90:8'h97]};
        direct = mb[7:6] == 2'b00 && mb[2:0] == 3'b110;
        rg     = {sreg, mb[5:3]};                     // Segment registers sit in the upper half
        rm     = {1'b0, mb[2:0]};
        if ((op < 8'h40 && op[2:1] == 2'b10) ||
            op inside {[8'h80:8'h83], 8'hA8, 8'hA9, 8'hC6, 8'hC7})
        begin
            r.need_imm = 1'b1;
            r.imm_size = op == 8'h81 || (op[7:4] != 4'h8 && op[0]);   // 83 takes imm8
        end
        else if (op inside {8'h9A, 8'hEA, 8'hC2, [8'hB0:8'hBF]})
        begin
            r.need_imm = 1'b1;
            r.imm_size = op[7:4] != 4'hB || op[3];    // MOV reg,imm has W in bit 3
        end
        r.need_imm   = r.need_imm || op inside {8'hC0, 8'hC1, [8'hE4:8'hE7]};
        r.unknown    = !(op < 8'h40 || pair || sreg || rm_dst || shift || branch || single ||
                         r.need_imm || op inside {8'h60, 8'h98, 8'h99, [8'h9B:8'h9F],
                         [8'hA4:8'hA7], [8'hAA:8'hAF], 8'hC3, 8'hCB, 8'hF3, 8'hFA, 8'hFC});
        r.need_modrm = pair | sreg | rm_dst | shift;
        r.byte_word  = (op inside {[8'hB0:8'hBF], [8'h8C:8'h8F]}) ? op[3] : op[0];
        if (branch)
        begin
            r.need_disp = 1'b1;
            r.disp_size = op inside {8'hE9, 8'h9A, 8'hEA};
        end
        else if (r.need_modrm)
        begin
            r.need_disp = mb[7:6] == 2'b01 || mb[7:6] == 2'b10 || direct;
            r.disp_size = mb[7:6] == 2'b10 || direct;
        end
        if (pair || sreg)
        begin
            r.dst = op[1] ? rg : rm;                  // D set means reg is written
            r.src = op[1] ? rm : rg;
        end
        if (rm_dst)
            r.dst = rm;
        if (shift)
        begin
            r.src = rm;
            r.dst = rm;
        end
        if (single)
            r.src = {1'b0, op[2:0]};
        if (op inside {[8'hB0:8'hBF]})
            r.dst = {1'b0, op[2:0]};
        return r;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        check_count++;
        if (actual !== expected)
        begin
            error_count++;
            $display("FAIL %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // One strobe, left high so that the next call is back to back
    task automatic send(input string test, input logic [7:0] op, input logic [7:0] mb);
        @(negedge clk);
        opcode   = op;
        modrm    = mb;
        in_valid = 1'b1;
        exp_q.push_back(expected_info(op, mb));
        due_q.push_back(cycle + 1);
        name_q.push_back($sformatf("%s op %02h modrm %02h", test, op, mb));
        sent_count++;
    endtask

    // Inputs keep moving while idle so a changing info shows up
    task automatic idle_cycles(input int n);
        repeat (n)
        begin
            @(negedge clk);
            in_valid = 1'b0;
            opcode   = random_byte();
            modrm    = random_byte();
        end
    endtask

    task automatic finish_test(input string test);
        int waited;
        waited = 0;
        idle_cycles(1);
        while (exp_q.size() != 0 && waited < 20)
        begin
            idle_cycles(1);
            waited++;
        end
        if (exp_q.size() != 0)
        begin
            $display("timeout waiting for out_valid in test %s", test);
            $display("tests failed");
            $finish;
        end
        else
        begin
            $display("test %s: %0d decodes, %0d errors", test, sent_count,
                     error_count - error_mark);
            sent_count = 0;
            error_mark = error_count;
        end
    endtask

    initial
    begin : compare_outputs
        decode_pkg::decode_info_t held_info;
        forever
        begin
            @(negedge clk);
            if (!rst_n)
                held_info = '0;
            else if (out_valid && exp_q.size() == 0)
            begin
                error_count++;
                $display("out_valid rose with no strobe pending at cycle %0d", cycle);
            end
            else if (out_valid)
            begin
                if (due_q.pop_front() != cycle)
                begin
                    error_count++;
                    $display("out_valid for %s arrived at the wrong cycle", name_q[0]);
                end
                check_value(name_q.pop_front(), exp_q.pop_front(), info);
                held_info = info;
            end
            else
                check_value("info hold", held_info, info);   // No strobe, no change
        end
    end

    initial
    begin
        logic [7:0] dir_ops [18];
        logic [7:0] mod_ops [13];
        dir_ops  = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h28, 8'h29, 8'h2A, 8'h2B, 8'h38,
                     8'h39, 8'h3A, 8'h3B, 8'h88, 8'h89, 8'h8A, 8'h8B, 8'h8C, 8'h8E};
        mod_ops  = '{8'h00, 8'h03, 8'h80, 8'h83, 8'h88, 8'h8B, 8'h8C, 8'h8E, 8'hC0,
                     8'hC6, 8'hC7, 8'hD1, 8'hD3};
        rst_n    = 1'b0;
        in_valid = 1'b0;
        opcode   = '0;
        modrm    = '0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        for (int op = 0; op < 256; op++)
            send("sweep", op[7:0], random_byte());
        finish_test("sweep");

        foreach (dir_ops[i])
        begin
            send("direction", dir_ops[i], random_byte());
            send("direction", dir_ops[i], random_byte());
        end
        finish_test("direction");

        // Every mod and rm pair with a random reg field
        foreach (mod_ops[i])
            for (int m = 0; m < 32; m++)
                send("modrm", mod_ops[i], (random_byte() & 8'h38) | {m[4:3], 3'b000, m[2:0]});
        finish_test("modrm");

        for (int op = 8'h70; op < 8'hF0; op++)
            if (op < 8'h80 || op inside {8'h9A, 8'hE2, 8'hE9, 8'hEA, 8'hEB})
                for (int m = 0; m < 4; m++)
                    send("branch", op[7:0], (random_byte() & 8'h3F) | {m[1:0], 6'b0});
        finish_test("branch");

        repeat (16)
            send("strobes", random_byte(), random_byte());
        repeat (48)
        begin
            send("strobes", random_byte(), random_byte());
            idle_cycles(random_byte() % 4);
        end
        finish_test("strobes");

        // Strobes held high through reset must leave nothing behind
        @(negedge clk);
        rst_n    = 1'b0;
        in_valid = 1'b1;
        opcode   = 8'h81;
        modrm    = random_byte();
        repeat (4) @(negedge clk);
        check_value("reset out_valid", 0, out_valid);
        check_value("reset info", 0, info);
        rst_n    = 1'b1;
        in_valid = 1'b0;
        repeat (8)
            send("reset", random_byte(), random_byte());
        finish_test("reset");

        $display("checks %0d, errors %0d, assertion failures %0d", check_count, error_count,
                 decode_stage_inst.sva_inst.assert_failures);
        if (error_count + decode_stage_inst.sva_inst.assert_failures == 0)
            $display("all tests passed");
        else
            $display("tests failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verification/decode_stage_sva.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module decode_stage_sva
(
    input logic                     clk,
    input logic                     rst_n,
    input logic                     in_valid,
    input decode_pkg::modrm_t       modrm,
    input logic                     out_valid,
    input decode_pkg::decode_info_t info
);

    int assert_failures = 0;

    // Synchronous reset clears the strobe on the next edge
    reset_clears_valid: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else
        begin
            assert_failures++;
            $error("out_valid set after a reset cycle");
        end

    valid_one_cycle: assert property (@(posedge clk) rst_n |=> out_valid == $past(in_valid))
        else
        begin
            assert_failures++;
            $error("out_valid does not follow in_valid by one cycle");
        end

    // A register operand never carries a displacement
    no_disp_mod_reg: assert property (@(posedge clk)
        rst_n && in_valid && modrm.mod == `DEC_MOD_REG |=> !(info.need_modrm && info.need_disp))
        else
        begin
            assert_failures++;
            $error("need_disp set for a mod 11 ModR/M decode");
        end

endmodule

bind decode_stage decode_stage_sva sva_inst
(
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .modrm     (modrm),
    .out_valid (out_valid),
    .info      (info)
);

`default_nettype wire

//--- verilog/decode_stage.sv
`timescale 1ns/100ps
`default_nettype none

module decode_stage
(
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     in_valid,
    input  decode_pkg::opcode_t      opcode,
    input  decode_pkg::modrm_t       modrm,
    output logic                     out_valid,
    output decode_pkg::decode_info_t info
);

    decode_pkg::op_class_t    op_class;
    logic                     need_modrm;
    logic                     need_imm;
    logic                     imm_size;
    logic                     byte_word;
    logic                     fixed_disp16;
    logic                     unknown;
    logic                     need_disp;
    logic                     disp_size;
    decode_pkg::reg_id_t      src;
    decode_pkg::reg_id_t      dst;
    decode_pkg::decode_info_t info_next;

    opcode_classifier opcode_classifier_inst
    (
        .opcode       (opcode),
        .op_class     (op_class),
        .need_modrm   (need_modrm),
        .need_imm     (need_imm),
        .imm_size     (imm_size),
        .byte_word    (byte_word),
        .fixed_disp16 (fixed_disp16),
        .unknown      (unknown)
    );

    displacement_sizer displacement_sizer_inst
    (
        .modrm        (modrm),
        .op_class     (op_class),
        .need_modrm   (need_modrm),
        .fixed_disp16 (fixed_disp16),
        .need_disp    (need_disp),
        .disp_size    (disp_size)
    );

    operand_selector operand_selector_inst
    (
        .opcode   (opcode),
        .modrm    (modrm),
        .op_class (op_class),
        .src      (src),
        .dst      (dst)
    );

    always_comb
    begin
        info_next            = '0;
        info_next.need_modrm = need_modrm;
        info_next.need_disp  = need_disp;
        info_next.disp_size  = disp_size;
        info_next.need_imm   = need_imm;
        info_next.imm_size   = imm_size;
        info_next.byte_word  = byte_word;
        info_next.unknown    = unknown;
        info_next.src        = src;
        info_next.dst        = dst;
    end

    // One-cycle output register, info holds between strobes
    always_ff @(posedge clk)
    begin
        if (!rst_n)
        begin
            out_valid <= 1'b0;
            info      <= '0;
        end
        else
        begin
            out_valid <= in_valid;
            if (in_valid)
            begin
                info <= info_next;
            end
        end
    end

endmodule

`default_nettype wire

//--- verilog/operand_selector.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module operand_selector
(
    input  decode_pkg::opcode_t   opcode,
    input  decode_pkg::modrm_t    modrm,
    input  decode_pkg::op_class_t op_class,
    output decode_pkg::reg_id_t   src,
    output decode_pkg::reg_id_t   dst
);

    logic                   dir;
    decode_pkg::reg_field_t opcode_reg;
    decode_pkg::reg_id_t    reg_id;
    decode_pkg::reg_id_t    rm_id;
    decode_pkg::reg_id_t    sreg_id;
    decode_pkg::reg_id_t    opcode_id;

    assign dir        = opcode[1];                   // D bit, 1 means reg is the target
    assign opcode_reg = opcode[`DEC_FIELD_W-1:0];

    assign reg_id    = {1'b0, modrm.reg_fld};
    assign rm_id     = {1'b0, modrm.rm};
    assign sreg_id   = {1'b1, modrm.reg_fld};        // Segment register space
    assign opcode_id = {1'b0, opcode_reg};

    always_comb
    begin
        src = '0;
        dst = '0;
        if (op_class.alu_rm_r || op_class.mov_rm_r)
        begin
            dst = dir ? reg_id : rm_id;
            src = dir ? rm_id : reg_id;
        end
        else if (op_class.mov_rm_sreg)
        begin
            // 8E loads the segment register, 8C stores it
            dst = dir ? sreg_id : rm_id;
            src = dir ? rm_id : sreg_id;
        end
        else if (op_class.grp1_rm_imm || op_class.mov_rm_imm)
        begin
            dst = rm_id;
        end
        else if (op_class.mov_r_imm)
        begin
            dst = opcode_id;
        end
        else if (op_class.shift_rm)
        begin
            src = rm_id;                            // Read-modify-write on r/m
            dst = rm_id;
        end
        else if (op_class.single_reg)
        begin
            src = opcode_id;
        end
    end

endmodule

`default_nettype wire

//--- verilog/displacement_sizer.sv
`timescale 1ns/100ps
`default_nettype none

`include "decode_settings.svh"

module displacement_sizer
(
    input  decode_pkg::modrm_t    modrm,
    input  decode_pkg::op_class_t op_class,
    input  logic                  need_modrm,
    input  logic                  fixed_disp16,
    output logic                  need_disp,
    output logic                  disp_size
);

    logic mem_operand;
    logic direct_addr;
    logic modrm_disp;
    logic modrm_disp16;
    logic branch_disp;

    assign mem_operand = modrm.mod != `DEC_MOD_REG;
    assign direct_addr = modrm.mod == 2'b00 && modrm.rm == `DEC_RM_DIRECT;

    // mod 01 and 10 carry a displacement, mod 00 only for the direct address
    assign modrm_disp   = mem_operand && (modrm.mod != 2'b00 || direct_addr);
    assign modrm_disp16 = direct_addr || modrm.mod == 2'b10;

    assign branch_disp = op_class.disp_only | op_class.far_xfer;

    always_comb
    begin
        need_disp = 1'b0;
        disp_size = 1'b0;
        if (branch_disp)
        begin
            need_disp = 1'b1;
            disp_size = fixed_disp16;               // Short jumps take disp8
        end
        else if (need_modrm)
        begin
            need_disp = modrm_disp;
            disp_size = modrm_disp16;
        end
    end

endmodule

`default_nettype wire

//--- verilog/opcode_classifier.sv
`timescale 1ns/100ps
`default_nettype none

module opcode_classifier
(
    input  decode_pkg::opcode_t   opcode,
    output decode_pkg::op_class_t op_class,
    output logic                  need_modrm,
    output logic                  need_imm,
    output logic                  imm_size,
    output logic                  byte_word,
    output logic                  fixed_disp16,
    output logic                  unknown
);

    // Every form that is followed by a ModR/M byte
    assign need_modrm = op_class.alu_rm_r    | op_class.grp1_rm_imm |
                        op_class.mov_rm_r    | op_class.mov_rm_sreg |
                        op_class.mov_rm_imm  | op_class.shift_rm;

    // MOV r,imm and the 8C-8F group keep W in bit 3
    assign byte_word = (opcode[7:4] == 4'b1011 || opcode[7:2] == 6'b1000_11) ?
                       opcode[3] : opcode[0];

    always_comb
    begin
        op_class     = '0;
        need_imm     = 1'b0;
        imm_size     = 1'b0;
        fixed_disp16 = 1'b0;
        unknown      = 1'b0;
        casez (opcode)
            8'b00??_?0??: op_class.alu_rm_r = 1'b1;        // ADD..CMP r/m,r
            8'b00??_?10?:                                   // ADD..CMP acc,imm
            begin
                op_class.alu_acc_imm = 1'b1;
                need_imm             = 1'b1;
                imm_size             = opcode[0];
            end
            8'b00??_?11?: ;                                 // Seg push/pop, prefixes, BCD adjust
            8'b010?_????: op_class.single_reg = 1'b1;      // INC, DEC, PUSH, POP reg16
            8'b0110_0000: ;                                 // PUSHA
            8'b0111_????: op_class.disp_only = 1'b1;       // Jcc short
            8'b1000_00??:                                   // Group 1 r/m,imm
            begin
                op_class.grp1_rm_imm = 1'b1;
                need_imm             = 1'b1;
                imm_size             = !opcode[1] & opcode[0]; // 83 sign-extends imm8
            end
            8'b1000_10??: op_class.mov_rm_r = 1'b1;        // MOV r/m,r
            8'b1000_11?0: op_class.mov_rm_sreg = 1'b1;     // MOV r/m,sreg and back
            8'b1001_0???: op_class.single_reg = 1'b1;      // XCHG AX,reg and NOP
            8'b1001_100?: ;                                 // CBW, CWD
            8'b1001_1010:                                   // CALL far
            begin
                op_class.far_xfer = 1'b1;
                need_imm          = 1'b1;
                imm_size          = 1'b1;
                fixed_disp16      = 1'b1;
            end
            8'b1001_1011: ;                                 // WAIT
            8'b1001_11??: ;                                 // PUSHF, POPF, SAHF, LAHF
            8'b1010_01??: ;                                 // MOVS, CMPS
            8'b1010_100?:                                   // TEST acc,imm
            begin
                op_class.imm_only = 1'b1;
                need_imm          = 1'b1;
                imm_size          = opcode[0];
            end
            8'b1010_101?: ;                                 // STOS
            8'b1010_11??: ;                                 // LODS, SCAS
            8'b1011_????:                                   // MOV reg,imm
            begin
                op_class.mov_r_imm = 1'b1;
                need_imm           = 1'b1;
                imm_size           = opcode[3];
            end
            8'b1100_000?:                                   // Shift r/m,imm8
            begin
                op_class.shift_rm = 1'b1;
                need_imm          = 1'b1;
            end
            8'b1100_0010:                                   // RET imm16
            begin
                op_class.imm_only = 1'b1;
                need_imm          = 1'b1;
                imm_size          = 1'b1;
            end
            8'b1100_0011: ;                                 // RET near
            8'b1100_011?:                                   // MOV r/m,imm
            begin
                op_class.mov_rm_imm = 1'b1;
                need_imm            = 1'b1;
                imm_size            = opcode[0];
            end
            8'b1100_1011: ;                                 // RET far
            8'b1101_00??: op_class.shift_rm = 1'b1;        // Shift r/m by 1 or CL
            8'b1110_0010: op_class.disp_only = 1'b1;       // LOOP
            8'b1110_01??:                                   // IN, OUT with port byte
            begin
                op_class.imm_only = 1'b1;
                need_imm          = 1'b1;
            end
            8'b1110_1001:                                   // JMP near
            begin
                op_class.disp_only = 1'b1;
                fixed_disp16       = 1'b1;
            end
            8'b1110_1010:                                   // JMP far
            begin
                op_class.far_xfer = 1'b1;
                need_imm          = 1'b1;
                imm_size          = 1'b1;
                fixed_disp16      = 1'b1;
            end
            8'b1110_1011: op_class.disp_only = 1'b1;       // JMP short
            8'b1111_0011,                                   // REP
            8'b1111_1010,                                   // CLI
            8'b1111_1100: ;                                 // CLD
            default:      unknown = 1'b1;
        endcase
    end

endmodule

`default_nettype wire

//--- verilog/decode_pkg.sv
`default_nettype none

`include "decode_settings.svh"

package decode_pkg;

    typedef logic [`DEC_BYTE_W-1:0]   opcode_t;
    typedef logic [`DEC_REG_ID_W-1:0] reg_id_t;
    typedef logic [`DEC_FIELD_W-1:0]  reg_field_t;
    typedef logic [`DEC_MOD_W-1:0]    mod_field_t;

    // Second instruction byte
    typedef struct packed {
        mod_field_t mod;
        reg_field_t reg_fld;                // reg is a keyword
        reg_field_t rm;
    } modrm_t;

    // One bit per operand pattern, all clear for no operands or unknown
    typedef struct packed {
        logic alu_rm_r;                     // 00-3B, low bits 00-11
        logic alu_acc_imm;                  // ALU accumulator with immediate
        logic grp1_rm_imm;                  // 80-83
        logic mov_rm_r;                     // 88-8B
        logic mov_rm_sreg;                  // 8C and 8E
        logic mov_r_imm;                    // B0-BF
        logic mov_rm_imm;                   // C6 and C7
        logic single_reg;                   // 40-5F and 90-97
        logic shift_rm;                     // C0, C1, D0-D3
        logic disp_only;                    // Jcc, LOOP, JMP near and short
        logic far_xfer;                     // CALL far and JMP far
        logic imm_only;                     // IN/OUT, TEST acc, RET imm16
    } op_class_t;

    // Decoded result of one opcode and ModR/M pair
    typedef struct packed {
        logic    need_modrm;
        logic    need_disp;
        logic    disp_size;                 // 0 is 8 bits, 1 is 16 bits
        logic    need_imm;
        logic    imm_size;                  // 0 is 8 bits, 1 is 16 bits
        logic    byte_word;                 // W field
        logic    unknown;                   // Opcode outside decoded set
        reg_id_t src;
        reg_id_t dst;
    } decode_info_t;

endpackage

`default_nettype wire

//--- verilog/decode_settings.svh
`ifndef DECODE_SETTINGS_SVH
`define DECODE_SETTINGS_SVH

// Instruction byte layout
//   byte 1: opcode[7:2] D W
//   byte 2: mod[7:6] reg[5:3] rm[2:0]

// Width of one instruction byte
`define DEC_BYTE_W 8

// Register identifier, top bit marks a segment register
`define DEC_REG_ID_W 4

// Width of the reg and rm fields
`define DEC_FIELD_W 3

// Width of the mod field
`define DEC_MOD_W 2

// mod value for a register operand
`define DEC_MOD_REG 2'b11

// rm value that with mod 00 gives a direct 16-bit address
`define DEC_RM_DIRECT 3'b110

`endif
